/* flist.f */
bpmPkg.sv
gpioRegisters.sv
triggerCapture.sv
heartbeatGenerator.sv
markerDivider.sv
bpmTimingTop.sv
bpmTiming_checker.sv
bpmTimingTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the BPM timing testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module bpmTimingTb -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running past assertion errors so the testbench reports the verdict
output=$(./obj_dir/simv +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1

/* bpmTimingTb.sv */
`timescale 1ns/1ps
`default_nettype none

module bpmTimingTb;

    // One row of the register table
    typedef struct packed {
        logic [bpmPkg::regAddrWidth-1:0] addr;
        logic [bpmPkg::regDataWidth-1:0] data;
        logic [bpmPkg::regDataWidth-1:0] expected;
    } regEntryT;

    logic                                  sysClk = 1'b0;
    logic                                  arstN;
    bpmPkg::gpioWriteT                     gpioWrite;
    logic [bpmPkg::regAddrWidth-1:0]       readAddr;
    logic [bpmPkg::eventTriggerWidth-1:0]  eventTriggers;
    logic                                  switchReset;
    logic                                  switchDisplay;
    logic [7:0]                            dipSwitch;
    logic [bpmPkg::regDataWidth-1:0]       readData;
    logic [bpmPkg::triggerBusWidth-1:0]    triggerStrobes;
    logic                                  heartbeat;
    logic                                  faMarker;
    logic                                  saMarker;
    logic                                  relayControl;
    logic [1:0]                            spiMuxSel;

    int          errorCount = 0;
    int          testCount = 0;
    int          failedTests = 0;
    int          errorsAtStart = 0;
    logic [31:0] rngState = 32'hcc57;

    // Write data and the readback masked to the register width
    string    entryName [0:6] = '{"hbReloadMask", "faReloadMask", "saReloadMask",
        "interlockWrite", "spiMuxWrite", "unmappedLow", "unmappedHigh"};
    regEntryT regTable [0:6] = '{
        '{bpmPkg::regHeartbeatReload, 32'hF000_0030, 32'h0000_0030},
        '{bpmPkg::regFaReload,        32'hABCD_1234, 32'h0000_1234},
        '{bpmPkg::regSaReload,        32'hFF12_3456, 32'h0012_3456},
        '{bpmPkg::regInterlock,       32'h0000_0003, 32'h0000_0001},
        '{bpmPkg::regSpiMux,          32'hFFFF_FFFE, 32'h0000_0002},
        '{4'd8,                       32'hDEAD_BEEF, 32'h0000_0000},
        '{4'd15,                      32'h1234_5678, 32'h0000_0000}
    };

    bpmTimingTop DUT (.*);

    always #10 sysClk = ~sysClk;

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    task automatic checkWord(input string name, input logic [bpmPkg::regDataWidth-1:0] expected,
                             input logic [bpmPkg::regDataWidth-1:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkTriggers(input string name,
                                 input logic [bpmPkg::triggerBusWidth-1:0] expected,
                                 input logic [bpmPkg::triggerBusWidth-1:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic checkMarkers(input string name, input bpmPkg::markerStatusT expected,
                                input bpmPkg::markerStatusT actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
            errorCount++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Bus access and waits on the falling edge
    task automatic writeReg(input logic [bpmPkg::regAddrWidth-1:0] addr,
                            input logic [bpmPkg::regDataWidth-1:0] data);
        @(negedge sysClk);
        gpioWrite = '{strobe: 1'b1, addr: addr, data: data};
        @(negedge sysClk);
        gpioWrite.strobe = 1'b0;
    endtask

    // Registered readback lags the address by one cycle
    task automatic readReg(input logic [bpmPkg::regAddrWidth-1:0] addr,
                           output logic [bpmPkg::regDataWidth-1:0] data);
        @(negedge sysClk);
        readAddr = addr;
        @(negedge sysClk);
        data = readData;
    endtask

    // Pulse kinds are 0 heartbeat, 1 FA marker, 2 any trigger strobe and 3 SA marker
    task automatic waitPulse(input string name, input int kind, input int limit,
                             output int cycles);
        logic seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < limit) begin
            @(negedge sysClk);
            cycles++;
            case (kind)
                0: seen = heartbeat;
                1: seen = faMarker;
                3: seen = saMarker;
                default: seen = |triggerStrobes;
            endcase
        end
        if (!seen) begin
            $display("%s timed out: no pulse within %0d cycles", name, limit);
            errorCount++;
        end
    endtask

    // Soft trigger write with an optional second write at cycle rewriteAt
    task automatic watchSoftTrigger(input string name, input int rewriteAt);
        int pulses;
        int firstAt;
        pulses = 0;
        firstAt = 0;
        @(negedge sysClk);
        gpioWrite = '{strobe: 1'b1, addr: bpmPkg::regSoftTrigger, data: '0};
        for (int i = 1; i <= 30; i++) begin
            @(negedge sysClk);
            if (triggerStrobes != '0) begin
                checkTriggers(name, 7'h01, triggerStrobes);
                pulses++;
                if (firstAt == 0) begin
                    firstAt = i;
                end
            end
            gpioWrite.strobe = (i == rewriteAt);
        end
        if (firstAt == 0 || firstAt > 6) begin
            $display("%s: no soft trigger pulse within 6 cycles of the write", name);
            errorCount++;
        end
        checkWord(name, 32'd1, 32'(pulses));
    endtask

    task automatic endTest(input string name);
        testCount++;
        if (errorCount == errorsAtStart) begin
            $display("PASS %s", name);
        end else begin
            $display("FAIL %s", name);
            failedTests++;
        end
        errorsAtStart = errorCount;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    initial begin
        logic [31:0]                        word;
        logic [31:0]                        expected;
        logic [31:0]                        reload;
        logic [5:0]                         pattern;
        logic [bpmPkg::triggerBusWidth-1:0] lastPattern;
        bpmPkg::markerStatusT               expectedSync;
        int                                 cycles;
        int                                 polls;
        int                                 assertFails;

        gpioWrite     = '0;
        readAddr      = '0;
        eventTriggers = '0;
        switchReset   = 1'b0;
        switchDisplay = 1'b0;
        dipSwitch     = 8'h00;
        lastPattern   = '0;
        arstN         = 1'b1;
        // Falling edge at 1 ns fires the asynchronous reset
        #1 arstN = 1'b0;
        repeat (5) @(negedge sysClk);
        checkWord("resetReadData", '0, readData);
        checkTriggers("resetStrobes", '0, triggerStrobes);
        checkWord("resetOutputs", '0,
            32'({heartbeat, faMarker, saMarker, relayControl, spiMuxSel}));
        arstN = 1'b1;
        readReg(bpmPkg::regHeartbeatReload, word);
        checkWord("hbReloadDefault", 32'd98, word);
        readReg(bpmPkg::regFaReload, word);
        checkWord("faReloadDefault", 32'd9, word);
        readReg(bpmPkg::regSaReload, word);
        checkWord("saReloadDefault", 32'd99, word);
        endTest("resetDefaults");

        foreach (regTable[i]) begin
            writeReg(regTable[i].addr, regTable[i].data);
            readReg(regTable[i].addr, word);
            checkWord(entryName[i], regTable[i].expected, word);
            if (regTable[i].addr == bpmPkg::regInterlock) begin
                checkWord(entryName[i], 32'(regTable[i].expected[0]), 32'(relayControl));
            end
            if (regTable[i].addr == bpmPkg::regSpiMux) begin
                checkWord(entryName[i], 32'(regTable[i].expected[1:0]), 32'(spiMuxSel));
            end
            endTest(entryName[i]);
        end

        // Random rising patterns on the event lines
        for (int n = 0; n < 4; n++) begin
            rngState = xorshift(rngState);
            pattern = (rngState[5:0] == 6'd0) ? 6'd1 : rngState[5:0];
            @(negedge sysClk);
            eventTriggers = pattern;
            waitPulse("eventEdge", 2, 10, cycles);
            checkWord("eventLatency", 32'd3, 32'(cycles));
            checkTriggers("eventStrobe", {pattern, 1'b0}, triggerStrobes);
            for (int i = 0; i < 6; i++) begin
                @(negedge sysClk);
                checkTriggers("eventHeld", '0, triggerStrobes);
            end
            eventTriggers = '0;
            repeat (4) @(negedge sysClk);
        end
        endTest("eventTriggers");

        watchSoftTrigger("softTrigger", 0);
        watchSoftTrigger("softRetrigger", 3);
        lastPattern = 7'h01;
        readReg(bpmPkg::regUserStatus, word);
        checkTriggers("softLastPattern", lastPattern, word[22:16]);
        endTest("softTrigger");

        // Spacing is measured once the new reload is in use
        for (int n = 0; n < 3; n++) begin
            rngState = xorshift(rngState);
            reload = 32'(rngState[4:0]) + 32'd4;
            writeReg(bpmPkg::regHeartbeatReload, reload);
            waitPulse("heartbeatStart", 0, 200, cycles);
            waitPulse("heartbeatPeriod", 0, 200, cycles);
            checkWord("heartbeatPeriod", reload + 32'd2, 32'(cycles));
        end
        endTest("heartbeatPeriod");

        writeReg(bpmPkg::regHeartbeatReload, 32'd98);
        writeReg(bpmPkg::regFaReload, 32'd9);
        writeReg(bpmPkg::regSaReload, 32'd6);
        expectedSync.faSynced = ((98 + 2) % (9 + 1)) == 0;
        expectedSync.saSynced = ((98 + 2) % (6 + 1)) == 0;
        waitPulse("markerHeartbeat1", 0, 200, cycles);
        waitPulse("markerHeartbeat2", 0, 200, cycles);
        waitPulse("faMarkerFirst", 1, 20, cycles);
        waitPulse("faMarkerNext", 1, 20, cycles);
        checkWord("faSpacing", 32'd10, 32'(cycles));
        readReg(bpmPkg::regMarkerStatus, word);
        checkMarkers("markerSynced", expectedSync, word[1:0]);
        waitPulse("saMarkerFirst", 3, 20, cycles);
        waitPulse("saMarkerNext", 3, 20, cycles);
        checkWord("saSpacing", 32'd7, 32'(cycles));
        endTest("markerSync");

        // Switches pass two synchronizer flops before readback
        for (int n = 0; n < 4; n++) begin
            rngState = xorshift(rngState);
            @(negedge sysClk);
            dipSwitch     = rngState[7:0];
            switchReset   = rngState[8];
            switchDisplay = rngState[9];
            readAddr      = bpmPkg::regUserStatus;
            expected = {rngState[8], rngState[9], 7'b0, lastPattern, 8'b0, rngState[7:0]};
            polls = 0;
            word = '0;
            while (word !== expected && polls < 6) begin
                @(negedge sysClk);
                word = readData;
                polls++;
            end
            checkWord("userStatus", expected, word);
        end
        endTest("userStatus");

        assertFails = DUT.timingChecker.pulseFails + DUT.timingChecker.strobeFails +
            DUT.timingChecker.resetFails;
        if (assertFails != 0) begin
            $display("Assertion checker flagged %0d failures", assertFails);
            errorCount += assertFails;
        end
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors", testCount,
            testCount - failedTests, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* bpmTiming_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module bpmTiming_checker (
    input wire                                  sysClk,
    input wire                                  arstN,
    input wire [bpmPkg::triggerBusWidth-1:0]    triggerStrobes,
    input wire                                  heartbeat,
    input wire                                  faMarker,
    input wire                                  saMarker
);

    int pulseFails = 0;
    int strobeFails = 0;
    int resetFails = 0;

    // Heartbeat and markers are single-cycle pulses
    pulseShape: assert property (@(posedge sysClk) disable iff (!arstN)
        ~|({heartbeat, faMarker, saMarker} & $past({heartbeat, faMarker, saMarker})))
    else begin
        $error("heartbeat or marker high on two consecutive cycles");
        pulseFails++;
    end

    // No trigger bit stays up for two cycles
    strobeShape: assert property (@(posedge sysClk) disable iff (!arstN)
        ~|(triggerStrobes & $past(triggerStrobes)))
    else begin
        $error("trigger strobe high on two consecutive cycles");
        strobeFails++;
    end

    strobesInReset: assert property (@(posedge sysClk) !arstN |-> triggerStrobes == '0)
    else begin
        $error("trigger strobes active during reset");
        resetFails++;
    end

endmodule

bind bpmTimingTop bpmTiming_checker timingChecker (
    .sysClk         (sysClk),
    .arstN          (arstN),
    .triggerStrobes (triggerStrobes),
    .heartbeat      (heartbeat),
    .faMarker       (faMarker),
    .saMarker       (saMarker)
);

`default_nettype wire

/* bpmTimingTop.sv */
`timescale 1ns/1ps
`default_nettype none

module bpmTimingTop (
    input  wire                                   sysClk,
    input  wire                                   arstN,
    input  wire bpmPkg::gpioWriteT                gpioWrite,
    input  wire [bpmPkg::regAddrWidth-1:0]        readAddr,
    input  wire [bpmPkg::eventTriggerWidth-1:0]   eventTriggers,
    input  wire                                   switchReset,
    input  wire                                   switchDisplay,
    input  wire [7:0]                             dipSwitch,
    output logic [bpmPkg::regDataWidth-1:0]       readData,
    output logic [bpmPkg::triggerBusWidth-1:0]    triggerStrobes,
    output logic                                  heartbeat,
    output logic                                  faMarker,
    output logic                                  saMarker,
    output logic                                  relayControl,
    output logic [1:0]                            spiMuxSel
);

    bpmPkg::timingConfigT  timingConfig;
    bpmPkg::markerStatusT  markerStatus;
    logic                  faSynced;
    logic                  saSynced;

    assign markerStatus = '{faSynced: faSynced, saSynced: saSynced};

    ////////////////////////////////////////////////////////////////////////////
    // Register bank
    gpioRegisters gpioRegs (
        .sysClk         (sysClk),
        .arstN          (arstN),
        .gpioWrite      (gpioWrite),
        .readAddr       (readAddr),
        .switchReset    (switchReset),
        .switchDisplay  (switchDisplay),
        .dipSwitch      (dipSwitch),
        .markerStatus   (markerStatus),
        .triggerStrobes (triggerStrobes),
        .timingConfig   (timingConfig),
        .relayControl   (relayControl),
        .spiMuxSel      (spiMuxSel),
        .readData       (readData)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Triggers and heartbeat
    triggerCapture trigCapture (
        .sysClk         (sysClk),
        .arstN          (arstN),
        .timingConfig   (timingConfig),
        .eventTriggers  (eventTriggers),
        .triggerStrobes (triggerStrobes)
    );

    heartbeatGenerator hbGen (
        .sysClk      (sysClk),
        .arstN       (arstN),
        .reloadValue (timingConfig.heartbeatReload),
        .heartbeat   (heartbeat)
    );

    // FA and SA markers, both aligned to the heartbeat
    markerDivider #(.countT(bpmPkg::faCountT)) faDivider (
        .sysClk      (sysClk),
        .arstN       (arstN),
        .reloadValue (timingConfig.faReload),
        .heartbeat   (heartbeat),
        .marker      (faMarker),
        .synced      (faSynced)
    );

    markerDivider #(.countT(bpmPkg::saCountT)) saDivider (
        .sysClk      (sysClk),
        .arstN       (arstN),
        .reloadValue (timingConfig.saReload),
        .heartbeat   (heartbeat),
        .marker      (saMarker),
        .synced      (saSynced)
    );

endmodule

`default_nettype wire

/* markerDivider.sv */
`timescale 1ns/1ps
`default_nettype none

module markerDivider #(
    parameter type countT = bpmPkg::faCountT
) (
    input  wire         sysClk,
    input  wire         arstN,
    input  wire countT  reloadValue,
    input  wire         heartbeat,
    output logic        marker,
    output logic        synced
);

    countT  count;
    logic   terminal;
    logic   restart;
    logic   lastMarker;

    assign terminal = (count == '0);
    assign restart  = heartbeat || terminal;

    // A heartbeat just after a terminal count would give back-to-back markers
    assign marker = restart && !lastMarker;

    ////////////////////////////////////////////////////////////////////////////
    // Divider
    always_ff @(posedge sysClk or negedge arstN) begin
        if (!arstN) begin
            // Start far from terminal so no marker comes out of reset
            count      <= '1;
            lastMarker <= 1'b0;
        end else begin
            lastMarker <= marker;
            if (restart) begin
                count <= reloadValue;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Alignment check at each heartbeat
    always_ff @(posedge sysClk or negedge arstN) begin
        if (!arstN) begin
            synced <= 1'b0;
        end else if (heartbeat) begin
            synced <= terminal;
        end
    end

endmodule

`default_nettype wire

/* heartbeatGenerator.sv */
`timescale 1ns/1ps
`default_nettype none

module heartbeatGenerator (
    input  wire                                 sysClk,
    input  wire                                 arstN,
    input  wire [bpmPkg::heartbeatWidth-1:0]    reloadValue,
    output logic                                heartbeat
);

    // Extra top bit flags the underflow
    logic [bpmPkg::heartbeatWidth:0] counter;

    assign heartbeat = counter[bpmPkg::heartbeatWidth];

    // Counts reload down to zero, then one cycle of underflow
    // so the period is reload + 2
    always_ff @(posedge sysClk or negedge arstN) begin
        if (!arstN) begin
            counter <= '0;
        end else if (heartbeat) begin
            counter <= {1'b0, reloadValue};
        end else begin
            counter <= counter - 1'b1;
        end
    end

endmodule

`default_nettype wire

/* triggerCapture.sv */
`timescale 1ns/1ps
`default_nettype none

module triggerCapture (
    input  wire                                   sysClk,
    input  wire                                   arstN,
    input  wire bpmPkg::timingConfigT             timingConfig,
    input  wire [bpmPkg::eventTriggerWidth-1:0]   eventTriggers,
    output logic [bpmPkg::triggerBusWidth-1:0]    triggerStrobes
);

    logic [bpmPkg::softTriggerCountWidth-1:0]  softCounter;
    logic                                      softLevel;
    logic [bpmPkg::triggerBusWidth-1:0]        syncStage1;
    logic [bpmPkg::triggerBusWidth-1:0]        syncStage2;
    logic [bpmPkg::triggerBusWidth-1:0]        lastLevel;

    // Top bit stays set while the stretch runs
    assign softLevel = softCounter[bpmPkg::softTriggerCountWidth-1];

    ////////////////////////////////////////////////////////////////////////////
    // Software trigger stretcher
    always_ff @(posedge sysClk or negedge arstN) begin
        if (!arstN) begin
            softCounter <= '0;
        end else if (timingConfig.softTriggerStrobe) begin
            // Retrigger reloads, level never drops in between
            softCounter <= '1;
        end else if (softLevel) begin
            softCounter <= softCounter - 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Synchronizer and rising edge detect
    always_ff @(posedge sysClk or negedge arstN) begin
        if (!arstN) begin
            syncStage1     <= '0;
            syncStage2     <= '0;
            lastLevel      <= '0;
            triggerStrobes <= '0;
        end else begin
            syncStage1     <= {eventTriggers, softLevel};
            syncStage2     <= syncStage1;
            lastLevel      <= syncStage2;
            triggerStrobes <= syncStage2 & ~lastLevel;
        end
    end

endmodule

`default_nettype wire

/* gpioRegisters.sv */
`timescale 1ns/1ps
`default_nettype none

module gpioRegisters (
    input  wire                                  sysClk,
    input  wire                                  arstN,
    input  wire bpmPkg::gpioWriteT               gpioWrite,
    input  wire [bpmPkg::regAddrWidth-1:0]       readAddr,
    input  wire                                  switchReset,
    input  wire                                  switchDisplay,
    input  wire [7:0]                            dipSwitch,
    input  wire bpmPkg::markerStatusT            markerStatus,
    input  wire [bpmPkg::triggerBusWidth-1:0]    triggerStrobes,
    output bpmPkg::timingConfigT                 timingConfig,
    output logic                                 relayControl,
    output logic [1:0]                           spiMuxSel,
    output logic [bpmPkg::regDataWidth-1:0]      readData
);

    logic [1:0]                          switchResetSync;
    logic [1:0]                          switchDisplaySync;
    logic [bpmPkg::triggerBusWidth-1:0]  lastTriggers;
    logic [bpmPkg::regDataWidth-1:0]     readWord;

    ////////////////////////////////////////////////////////////////////////////
    // Write decode
    always_ff @(posedge sysClk or negedge arstN) begin
        if (!arstN) begin
            timingConfig.heartbeatReload   <= bpmPkg::heartbeatReloadDefault;
            timingConfig.faReload          <= bpmPkg::faReloadDefault;
            timingConfig.saReload          <= bpmPkg::saReloadDefault;
            timingConfig.softTriggerStrobe <= 1'b0;
            relayControl                   <= 1'b0;
            spiMuxSel                      <= 2'b00;
        end else begin
            // Soft trigger is a single-cycle pulse, nothing is stored
            timingConfig.softTriggerStrobe <= gpioWrite.strobe &&
                (gpioWrite.addr == bpmPkg::regSoftTrigger);
            if (gpioWrite.strobe) begin
                case (gpioWrite.addr)
                    bpmPkg::regHeartbeatReload: begin
                        timingConfig.heartbeatReload <=
                            gpioWrite.data[bpmPkg::heartbeatWidth-1:0];
                    end
                    bpmPkg::regFaReload: begin
                        timingConfig.faReload <= gpioWrite.data[bpmPkg::faCountWidth-1:0];
                    end
                    bpmPkg::regSaReload: begin
                        timingConfig.saReload <= gpioWrite.data[bpmPkg::saCountWidth-1:0];
                    end
                    bpmPkg::regInterlock: begin
                        relayControl <= gpioWrite.data[0];
                    end
                    bpmPkg::regSpiMux: begin
                        spiMuxSel <= gpioWrite.data[1:0];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Front panel switches and trigger history
    always_ff @(posedge sysClk or negedge arstN) begin
        if (!arstN) begin
            switchResetSync   <= 2'b00;
            switchDisplaySync <= 2'b00;
            lastTriggers      <= '0;
        end else begin
            switchResetSync   <= {switchResetSync[0], switchReset};
            switchDisplaySync <= {switchDisplaySync[0], switchDisplay};
            // Hold the most recent pattern that had any strobe set
            if (|triggerStrobes) begin
                lastTriggers <= triggerStrobes;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Readback
    always_comb begin
        readWord = '0;
        case (readAddr)
            bpmPkg::regHeartbeatReload: begin
                readWord[bpmPkg::heartbeatWidth-1:0] = timingConfig.heartbeatReload;
            end
            bpmPkg::regFaReload: begin
                readWord[bpmPkg::faCountWidth-1:0] = timingConfig.faReload;
            end
            bpmPkg::regSaReload: begin
                readWord[bpmPkg::saCountWidth-1:0] = timingConfig.saReload;
            end
            bpmPkg::regInterlock: begin
                readWord[0] = relayControl;
            end
            bpmPkg::regSpiMux: begin
                readWord[1:0] = spiMuxSel;
            end
            bpmPkg::regUserStatus: begin
                readWord[31] = switchResetSync[1];
                readWord[30] = switchDisplaySync[1];
                readWord[16 +: bpmPkg::triggerBusWidth] = lastTriggers;
                readWord[7:0] = dipSwitch;
            end
            bpmPkg::regMarkerStatus: begin
                readWord[1] = markerStatus.faSynced;
                readWord[0] = markerStatus.saSynced;
            end
            default: begin
                readWord = '0;
            end
        endcase
    end

    always_ff @(posedge sysClk or negedge arstN) begin
        if (!arstN) begin
            readData <= '0;
        end else begin
            readData <= readWord;
        end
    end

endmodule

`default_nettype wire

/* bpmPkg.sv */
`default_nettype none

package bpmPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    localparam int regAddrWidth      = 4;
    localparam int regDataWidth      = 32;
    localparam int triggerBusWidth   = 7;
    localparam int eventTriggerWidth = 6;
    localparam int heartbeatWidth    = 28;
    localparam int faCountWidth      = 16;
    localparam int saCountWidth      = 24;

    // Soft trigger level length in cycles, counter gets one extra bit
    localparam int softTriggerStretch    = 8;
    localparam int softTriggerCountWidth = $clog2(softTriggerStretch) + 1;

    ////////////////////////////////////////////////////////////////////////////
    // Register map
    localparam logic [regAddrWidth-1:0] regSoftTrigger     = 4'd0;
    localparam logic [regAddrWidth-1:0] regHeartbeatReload = 4'd1;
    localparam logic [regAddrWidth-1:0] regFaReload        = 4'd2;
    localparam logic [regAddrWidth-1:0] regSaReload        = 4'd3;
    localparam logic [regAddrWidth-1:0] regInterlock       = 4'd4;
    localparam logic [regAddrWidth-1:0] regSpiMux          = 4'd5;
    localparam logic [regAddrWidth-1:0] regUserStatus      = 4'd6;
    localparam logic [regAddrWidth-1:0] regMarkerStatus    = 4'd7;

    typedef logic [faCountWidth-1:0] faCountT;
    typedef logic [saCountWidth-1:0] saCountT;

    // Reload values after reset
    localparam logic [heartbeatWidth-1:0] heartbeatReloadDefault = 28'd98;
    localparam faCountT faReloadDefault = 16'd9;
    localparam saCountT saReloadDefault = 24'd99;

    ////////////////////////////////////////////////////////////////////////////
    // Bundles
    typedef struct packed {
        logic                    strobe;
        logic [regAddrWidth-1:0] addr;
        logic [regDataWidth-1:0] data;
    } gpioWriteT;

    typedef struct packed {
        logic [heartbeatWidth-1:0] heartbeatReload;
        faCountT                   faReload;
        saCountT                   saReload;
        logic                      softTriggerStrobe;
    } timingConfigT;

    typedef struct packed {
        logic faSynced;
        logic saSynced;
    } markerStatusT;

endpackage

`default_nettype wire
